// ==== snd_regs_pkg.sv ====
package snd_regs_pkg;

   localparam logic [15:0] addr_nr41 = 16'hff20;   // Sound length.
   localparam logic [15:0] addr_nr42 = 16'hff21;   // Volume envelope.
   localparam logic [15:0] addr_nr43 = 16'hff22;   // Polynomial counter.
   localparam logic [15:0] addr_nr44 = 16'hff23;   // Restart and length enable.

   typedef struct packed {
      logic [1:0] unused;        // Reads back as ones.
      logic [5:0] length_load;   // Length runs for 64 minus this many ticks.
   } nr41_t;

   typedef struct packed {
      logic [3:0] init_volume;   // Volume loaded on restart.
      logic       dir_up;        // Envelope counts toward 15 when set.
      logic [2:0] env_period;    // Envelope ticks per step, zero stops it.
   } nr42_t;

   typedef struct packed {
      logic [3:0] clock_shift;   // Step period is scaled by two to this power.
      logic       short_mode;    // Selects the 7-bit sequence.
      logic [2:0] div_code;      // Index into the divisor table.
   } nr43_t;

   typedef struct packed {
      logic       restart;       // Writing a one starts the voice.
      logic       length_en;     // Lets the length counter stop the voice.
      logic [5:0] unused;
   } nr44_t;

   typedef struct packed {
      logic [15:0] addr;
      logic        write;        // High for a write, low for a read.
      logic [7:0]  wdata;
   } reg_req_t;

endpackage

// ==== snd_timing_pkg.sv ====
package snd_timing_pkg;

   typedef logic signed [7:0] sample_t;   // Noise sample, plus or minus the volume.

   // Base step period in step units for each divisor code.
   function automatic logic [7:0] divisor_base(input logic [2:0] code);
      logic [7:0] base;
      case (code)
         3'd0:    base = 8'd8;     // Code zero acts as half a unit of 16.
         3'd1:    base = 8'd16;
         3'd2:    base = 8'd32;
         3'd3:    base = 8'd48;
         3'd4:    base = 8'd64;
         3'd5:    base = 8'd80;
         3'd6:    base = 8'd96;
         default: base = 8'd112;
      endcase
      return base;
   endfunction

endpackage

// ==== noise_regs.sv ====
`timescale 1ns/1ps

module noise_regs (
   input  logic                   I_CLK_33MHZ,
   input  logic                   I_RESET,
   input  logic                   req_valid,
   output logic                   req_ready,
   input  snd_regs_pkg::reg_req_t req,
   output logic [7:0]             rdata,
   output logic                   rvalid,
   output snd_regs_pkg::nr41_t    nr41,
   output snd_regs_pkg::nr42_t    nr42,
   output snd_regs_pkg::nr43_t    nr43,
   output logic                   length_en,
   output logic                   restart
);

   snd_regs_pkg::nr44_t nr44;
   snd_regs_pkg::nr44_t nr44_wr;   // Write data seen through the NR44 layout.
   logic                accept;
   logic                wr_accept;
   logic                rd_accept;
   logic [7:0]          read_mux;

   assign req_ready = ~rvalid;   // One idle cycle while the read data is out.
   assign accept    = req_valid & req_ready;
   assign wr_accept = accept & req.write;
   assign rd_accept = accept & ~req.write;
   assign nr44_wr   = req.wdata;
   assign length_en = nr44.length_en;

   // Unused bits and unknown addresses read as ones.
   always_comb begin
      case (req.addr)
         snd_regs_pkg::addr_nr41: read_mux = {2'b11, nr41.length_load};
         snd_regs_pkg::addr_nr42: read_mux = nr42;
         snd_regs_pkg::addr_nr43: read_mux = nr43;
         snd_regs_pkg::addr_nr44: read_mux = {nr44.restart, nr44.length_en, 6'h3f};
         default:                 read_mux = 8'hff;
      endcase
   end

   always_ff @(posedge I_CLK_33MHZ) begin
      if (I_RESET) begin
         nr41    <= '0;
         nr42    <= '0;
         nr43    <= '0;
         nr44    <= '0;
         rvalid  <= 1'b0;
         restart <= 1'b0;
      end else begin
         rvalid  <= rd_accept;
         restart <= wr_accept && (req.addr == snd_regs_pkg::addr_nr44) && nr44_wr.restart;
         if (wr_accept) begin
            case (req.addr)
               snd_regs_pkg::addr_nr41: nr41 <= req.wdata;
               snd_regs_pkg::addr_nr42: nr42 <= req.wdata;
               snd_regs_pkg::addr_nr43: nr43 <= req.wdata;
               snd_regs_pkg::addr_nr44: nr44 <= nr44_wr;
               default: ;                                     // Other addresses are dropped.
            endcase
         end
      end
   end

   always_ff @(posedge I_CLK_33MHZ) begin
      if (rd_accept) begin
         rdata <= read_mux;   // Valid in the cycle that rvalid is high.
      end
   end

endmodule

// ==== noise_tick_gen.sv ====
`timescale 1ns/1ps

module noise_tick_gen #(
   parameter int LEN_TICK_CLOCKS  = 128906,
   parameter int ENV_TICK_CLOCKS  = 515625,
   parameter int STEP_UNIT_CLOCKS = 8
) (
   input  logic                I_CLK_33MHZ,
   input  logic                I_RESET,
   input  logic                restart,
   input  snd_regs_pkg::nr43_t nr43,
   output logic                length_tick,
   output logic                env_tick,
   output logic                step_req,
   input  logic                step_ack
);

   localparam logic [31:0] TICK_LAST [2] = '{32'(LEN_TICK_CLOCKS - 1),
                                              32'(ENV_TICK_CLOCKS - 1)};
   localparam logic [31:0] STEP_UNIT    = 32'(STEP_UNIT_CLOCKS);

   logic [1:0]  ticks;
   logic [31:0] step_period;
   logic [31:0] step_cnt;

   // Index 0 is the length prescaler and index 1 the envelope prescaler.
   for (genvar i = 0; i < 2; i++) begin : g_tick
      logic [31:0] cnt;
      logic        pulse;

      always_ff @(posedge I_CLK_33MHZ) begin
         if (I_RESET || restart) begin
            cnt   <= '0;
            pulse <= 1'b0;
         end else if (cnt == TICK_LAST[i]) begin
            cnt   <= '0;
            pulse <= 1'b1;   // One cycle wide.
         end else begin
            cnt   <= cnt + 32'd1;
            pulse <= 1'b0;
         end
      end

      assign ticks[i] = pulse;
   end

   assign length_tick = ticks[0];
   assign env_tick    = ticks[1];

   // Base from the table, scaled by the shift and the unit length in clocks.
   assign step_period = ({24'd0, snd_timing_pkg::divisor_base(nr43.div_code)}
                         << nr43.clock_shift) * STEP_UNIT;

   always_ff @(posedge I_CLK_33MHZ) begin
      if (I_RESET || restart || step_ack) begin
         step_cnt <= '0;
         step_req <= 1'b0;
      end else if (!step_req) begin
         if (step_cnt >= step_period - 32'd1) begin
            step_req <= 1'b1;   // Held until the output stage takes the step.
         end else begin
            step_cnt <= step_cnt + 32'd1;
         end
      end
   end

endmodule

// ==== noise_env_length.sv ====
`timescale 1ns/1ps

module noise_env_length (
   input  logic                I_CLK_33MHZ,
   input  logic                I_RESET,
   input  logic                restart,
   input  snd_regs_pkg::nr41_t nr41,
   input  snd_regs_pkg::nr42_t nr42,
   input  logic                length_en,
   input  logic                length_tick,
   input  logic                env_tick,
   output logic                ch_on,
   output logic [3:0]          volume
);

   logic [5:0] len_cnt;
   logic [2:0] env_cnt;
   logic       env_step;

   // The envelope only moves while the voice plays and the period is set.
   assign env_step = env_tick && ch_on && (nr42.env_period != 3'd0);

   always_ff @(posedge I_CLK_33MHZ) begin
      if (I_RESET) begin
         ch_on   <= 1'b0;
         len_cnt <= '0;
      end else if (restart) begin
         ch_on   <= 1'b1;
         len_cnt <= nr41.length_load;
      end else if (length_tick && length_en && ch_on) begin
         if (len_cnt == 6'h3f) begin
            ch_on <= 1'b0;   // Tick number 64 minus the load ends the sound.
         end else begin
            len_cnt <= len_cnt + 6'd1;
         end
      end
   end

   always_ff @(posedge I_CLK_33MHZ) begin
      if (I_RESET) begin
         env_cnt <= '0;
         volume  <= '0;
      end else if (restart) begin
         env_cnt <= '0;
         volume  <= nr42.init_volume;
      end else if (env_step) begin
         if (env_cnt >= nr42.env_period - 3'd1) begin
            env_cnt <= '0;
            if (nr42.dir_up && (volume != 4'hf)) begin
               volume <= volume + 4'd1;
            end else if (!nr42.dir_up && (volume != 4'h0)) begin
               volume <= volume - 4'd1;
            end
            // At either end the volume simply stays.
         end else begin
            env_cnt <= env_cnt + 3'd1;
         end
      end
   end

endmodule

// ==== noise_lfsr_out.sv ====
`timescale 1ns/1ps

module noise_lfsr_out (
   input  logic                    I_CLK_33MHZ,
   input  logic                    I_RESET,
   input  logic                    restart,
   input  logic                    short_mode,
   input  logic                    ch_on,
   input  logic [3:0]              volume,
   input  logic                    step_req,
   output logic                    step_ack,
   output logic                    sample_valid,
   output snd_timing_pkg::sample_t sample,
   input  logic                    sample_ready
);

   logic [14:0]             lfsr;
   logic [14:0]             lfsr_next;
   logic                    feedback;
   logic                    slot_free;
   snd_timing_pkg::sample_t magnitude;

   assign feedback  = lfsr[0] ^ lfsr[1];
   assign magnitude = {4'b0000, volume};

   always_comb begin
      lfsr_next = {feedback, lfsr[14:1]};
      if (short_mode) begin
         lfsr_next[6] = feedback;   // Shortens the sequence to 127 states.
      end
   end

   // The output register is free when empty or being taken this cycle.
   assign slot_free = ~sample_valid | sample_ready;
   assign step_ack  = step_req & ch_on & slot_free & ~restart;

   always_ff @(posedge I_CLK_33MHZ) begin
      if (I_RESET || restart) begin
         lfsr <= '1;
      end else if (step_ack) begin
         lfsr <= lfsr_next;
      end
   end

   always_ff @(posedge I_CLK_33MHZ) begin
      if (I_RESET) begin
         sample_valid <= 1'b0;
      end else if (step_ack) begin
         sample_valid <= 1'b1;
      end else if (sample_ready) begin
         sample_valid <= 1'b0;
      end
   end

   always_ff @(posedge I_CLK_33MHZ) begin
      if (step_ack) begin
         sample <= lfsr_next[0] ? -magnitude : magnitude;   // A one bit gives the low level.
      end
   end

endmodule

// ==== noise_channel_top.sv ====
`timescale 1ns/1ps

module noise_channel_top #(
   parameter int LEN_TICK_CLOCKS  = 128906,   // 256 Hz at 33 MHz.
   parameter int ENV_TICK_CLOCKS  = 515625,   // 64 Hz at 33 MHz.
   parameter int STEP_UNIT_CLOCKS = 8
) (
   input  logic                    I_CLK_33MHZ,
   input  logic                    I_RESET,
   input  logic                    req_valid,
   output logic                    req_ready,
   input  snd_regs_pkg::reg_req_t  req,
   output logic [7:0]              rdata,
   output logic                    rvalid,
   output logic                    ch_on,
   output logic                    sample_valid,
   output snd_timing_pkg::sample_t sample,
   input  logic                    sample_ready
);

   snd_regs_pkg::nr41_t nr41;
   snd_regs_pkg::nr42_t nr42;
   snd_regs_pkg::nr43_t nr43;
   logic                length_en;
   logic                restart;
   logic                length_tick;
   logic                env_tick;
   logic                step_req;
   logic                step_ack;
   logic [3:0]          volume;

   noise_regs regs_i (
      .I_CLK_33MHZ (I_CLK_33MHZ),
      .I_RESET     (I_RESET),
      .req_valid   (req_valid),
      .req_ready   (req_ready),
      .req         (req),
      .rdata       (rdata),
      .rvalid      (rvalid),
      .nr41        (nr41),
      .nr42        (nr42),
      .nr43        (nr43),
      .length_en   (length_en),
      .restart     (restart)
   );

   noise_tick_gen #(
      .LEN_TICK_CLOCKS  (LEN_TICK_CLOCKS),
      .ENV_TICK_CLOCKS  (ENV_TICK_CLOCKS),
      .STEP_UNIT_CLOCKS (STEP_UNIT_CLOCKS)
   ) ticks_i (
      .I_CLK_33MHZ (I_CLK_33MHZ),
      .I_RESET     (I_RESET),
      .restart     (restart),
      .nr43        (nr43),
      .length_tick (length_tick),
      .env_tick    (env_tick),
      .step_req    (step_req),
      .step_ack    (step_ack)
   );

   noise_env_length env_i (
      .I_CLK_33MHZ (I_CLK_33MHZ),
      .I_RESET     (I_RESET),
      .restart     (restart),
      .nr41        (nr41),
      .nr42        (nr42),
      .length_en   (length_en),
      .length_tick (length_tick),
      .env_tick    (env_tick),
      .ch_on       (ch_on),
      .volume      (volume)
   );

   noise_lfsr_out lfsr_i (
      .I_CLK_33MHZ  (I_CLK_33MHZ),
      .I_RESET      (I_RESET),
      .restart      (restart),
      .short_mode   (nr43.short_mode),
      .ch_on        (ch_on),
      .volume       (volume),
      .step_req     (step_req),
      .step_ack     (step_ack),
      .sample_valid (sample_valid),
      .sample       (sample),
      .sample_ready (sample_ready)
   );

endmodule

// ==== noise_channel_assertions.sv ====
`timescale 1ns/1ps

module noise_channel_assertions (
   input logic                    I_CLK_33MHZ,
   input logic                    I_RESET,
   input logic                    req_valid,
   input logic                    req_ready,
   input snd_regs_pkg::reg_req_t  req,
   input logic                    rvalid,
   input logic                    sample_valid,
   input snd_timing_pkg::sample_t sample,
   input logic                    sample_ready
);

   int unsigned fail_count = 0;   // Number of failed protocol properties.

   // A waiting sample neither changes nor disappears.
   sample_hold_a : assert property (@(posedge I_CLK_33MHZ) disable iff (I_RESET)
      sample_valid && !sample_ready |=> sample_valid && $stable(sample))
   else begin
      $error("sample changed or was dropped while sample_ready was low");
      fail_count++;
   end

   read_resp_a : assert property (@(posedge I_CLK_33MHZ) disable iff (I_RESET)
      rvalid |-> $past(req_valid && req_ready && !req.write))
   else begin
      $error("rvalid without an accepted read in the previous cycle");
      fail_count++;
   end

   ready_gap_a : assert property (@(posedge I_CLK_33MHZ) disable iff (I_RESET)
      rvalid |-> !req_ready)
   else begin
      $error("req_ready high while rvalid is high");
      fail_count++;
   end

endmodule

bind noise_channel_top noise_channel_assertions protocol_chk_i (.*);

// ==== noise_channel_tb.sv ====
`timescale 1ns/1ps

module noise_channel_tb;

   localparam logic [15:0] REG_ADDR [4]    = '{snd_regs_pkg::addr_nr41, snd_regs_pkg::addr_nr42,
                                               snd_regs_pkg::addr_nr43, snd_regs_pkg::addr_nr44};
   localparam logic [7:0]  UNUSED_MASK [4] = '{8'hc0, 8'h00, 8'h00, 8'h3f};

   logic                    I_CLK_33MHZ = 1'b0;
   logic                    I_RESET;
   logic                    req_valid;
   logic                    req_ready;
   snd_regs_pkg::reg_req_t  req;
   logic [7:0]              rdata;
   logic                    rvalid;
   logic                    ch_on;
   logic                    sample_valid;
   snd_timing_pkg::sample_t sample;
   logic                    sample_ready;

   logic [31:0] rng = 32'h26a8;
   logic [14:0] model_lfsr;
   logic [7:0]  model_regs [4];
   logic        seq_bits [$];   // Sign bits of the received samples, one per step.
   int          value_errors = 0;
   int          other_errors = 0;

   noise_channel_top #(
      .LEN_TICK_CLOCKS  (64),
      .ENV_TICK_CLOCKS  (32),
      .STEP_UNIT_CLOCKS (1)
   ) dut_i (.*);

   always #2 I_CLK_33MHZ = ~I_CLK_33MHZ;

   // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit.
   function automatic logic [15:0] rand_bits(input int n);
      logic [15:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         rng = {rng[30:0], rng[31] ^ rng[21] ^ rng[1] ^ rng[0]};
         v   = {v[14:0], rng[0]};
      end
      return v;
   endfunction

   // Next noise sample from the reference shift register.
   function automatic snd_timing_pkg::sample_t model_step(input logic short_mode,
                                                          input logic [3:0] vol);
      logic                    fb;
      snd_timing_pkg::sample_t m;
      fb         = model_lfsr[0] ^ model_lfsr[1];
      model_lfsr = {fb, model_lfsr[14:1]};
      if (short_mode) begin
         model_lfsr[6] = fb;
      end
      m = {4'b0000, vol};
      return model_lfsr[0] ? -m : m;   // A one bit gives the low level.
   endfunction

   task automatic next_cycle;
      @(posedge I_CLK_33MHZ);
      #1;
   endtask

   task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
      assert (got == exp) else begin
         $display("Fail %s: got %h, expected %h", name, got, exp);
         value_errors++;
      end
   endtask

   task automatic reg_access(input logic [15:0] addr, input logic is_write,
                             input logic [7:0] wdata, output logic [7:0] data);
      int t;
      req_valid = 1'b1;
      req       = '{addr: addr, write: is_write, wdata: wdata};
      for (t = 0; t < 20 && !req_ready; t++) begin
         next_cycle();
      end
      assert (req_ready) else begin
         $display("Register request was not accepted within 20 cycles.");
         other_errors++;
      end
      next_cycle();
      req_valid = 1'b0;
      check_value("rvalid", 16'(rvalid), 16'(!is_write));   // Read data one cycle later.
      data = rdata;
   endtask

   task automatic take_sample(output snd_timing_pkg::sample_t s);
      int t;
      for (t = 0; t < 400; t++) begin
         sample_ready = rand_bits(1) != 16'd0;
         if (sample_valid && sample_ready) begin
            break;
         end
         next_cycle();
      end
      assert (t < 400) else begin
         $display("No sample was transferred within 400 cycles.");
         other_errors++;
      end
      s = sample;
      next_cycle();
   endtask

   // Old samples drain while the voice is set up and restarted.
   task automatic start_voice(input logic [7:0] nr42, input logic [7:0] nr43);
      logic [7:0] rd;
      sample_ready = 1'b1;
      reg_access(REG_ADDR[1], 1'b1, nr42, rd);
      reg_access(REG_ADDR[2], 1'b1, nr43, rd);
      reg_access(REG_ADDR[3], 1'b1, 8'h80, rd);
      next_cycle();
      next_cycle();
      model_lfsr = '1;
      seq_bits.delete();
   endtask

   initial begin
      snd_timing_pkg::sample_t s;
      snd_timing_pkg::sample_t mag;
      snd_timing_pkg::sample_t prev;
      snd_timing_pkg::sample_t exp_s;
      logic [7:0]  rd;
      logic [7:0]  w;
      logic [15:0] addr;
      logic [2:0]  sel;
      logic [3:0]  vol;
      logic        up;
      logic        short_m;
      logic        was_on;
      int          t;
      int          exp_len;

      I_RESET      = 1'b1;
      req_valid    = 1'b0;
      req          = '0;
      sample_ready = 1'b0;
      for (int i = 0; i < 4; i++) begin
         model_regs[i] = UNUSED_MASK[i];
      end
      repeat (3) @(posedge I_CLK_33MHZ);
      #1;
      I_RESET = 1'b0;
      check_value("reset outputs", 16'({req_ready, rvalid, ch_on, sample_valid}), 16'h8);

      for (int i = 0; i < 40; i++) begin
         sel  = 3'(rand_bits(3));
         w    = 8'(rand_bits(8));
         addr = (sel < 3'd4) ? REG_ADDR[sel[1:0]] : rand_bits(16);
         if (sel >= 3'd4 && addr[15:2] == REG_ADDR[0][15:2]) begin
            addr[8] = ~addr[8];   // Keeps unknown addresses off the register block.
         end
         reg_access(addr, 1'b1, w, rd);
         if (sel < 3'd4) begin
            model_regs[sel[1:0]] = w | UNUSED_MASK[sel[1:0]];
         end
         reg_access(addr, 1'b0, 8'h00, rd);
         check_value("rdata", 16'(rd), 16'((sel < 3'd4) ? model_regs[sel[1:0]] : 8'hff));
      end
      for (int i = 0; i < 4; i++) begin
         reg_access(REG_ADDR[2'(i)], 1'b0, 8'h00, rd);
         check_value("rdata", 16'(rd), 16'(model_regs[2'(i)]));
      end

      for (int mode = 0; mode < 2; mode++) begin
         short_m = (mode == 1);
         vol     = 4'(rand_bits(3)) + 4'd8;
         w       = 8'(rand_bits(1));
         start_voice({vol, 4'h0}, {4'd0, short_m, 2'b00, w[0]});
         for (int n = 0; n < 140; n++) begin
            take_sample(s);
            seq_bits.push_back(s < 0);
            check_value("sample", 16'(s), 16'(model_step(short_m, vol)));
            if (short_m && n >= 127) begin
               check_value("sample period", 16'(seq_bits[n]), 16'(seq_bits[n - 127]));
            end
         end
      end

      up  = rand_bits(1) != 16'd0;
      vol = 4'(rand_bits(4));
      start_voice({vol, up, 3'(rand_bits(2)) + 3'd1}, 8'h00);
      prev = {4'b0000, vol};
      for (int n = 0; n < 100; n++) begin
         take_sample(s);
         mag   = (s < 0) ? -s : s;
         exp_s = model_step(1'b0, 4'd1);   // The envelope sets the level, the model the sign.
         if (mag != 8'sd0) begin
            check_value("sample sign", 16'(s < 0), 16'(exp_s < 0));
         end
         assert (mag <= 8'sd15 && (mag == prev || mag == (up ? prev + 8'sd1 : prev - 8'sd1)))
         else begin
            $display("Fail volume: got %h after %h", mag, prev);
            value_errors++;
         end
         prev = mag;
      end
      assert (mag != {4'b0000, vol} || vol == (up ? 4'hf : 4'h0)) else begin
         $display("The envelope never changed the volume.");
         other_errors++;
      end

      for (int run = 0; run < 2; run++) begin
         w            = 8'(rand_bits(6));
         was_on       = ch_on;
         sample_ready = 1'b1;
         reg_access(REG_ADDR[0], 1'b1, w, rd);
         reg_access(REG_ADDR[3], 1'b1, 8'hc0, rd);
         check_value("ch_on", 16'(ch_on), 16'(was_on));   // Restart pulse is still in flight.
         next_cycle();
         check_value("ch_on", 16'(ch_on), 16'h1);
         for (t = 1; t < 4300 && ch_on; t++) begin
            next_cycle();
         end
         assert (!ch_on) else begin
            $display("ch_on did not fall within 4300 cycles.");
            other_errors++;
         end
         exp_len = (64 - int'(w[5:0])) * 64;
         assert (t >= exp_len - 64 && t <= exp_len + 64) else begin
            $display("Fail ch_on length: got %h cycles, expected %h", t, exp_len);
            value_errors++;
         end
         next_cycle();   // A step taken in the falling cycle drains here.
         for (int n = 0; n < 100; n++) begin
            assert (!sample_valid) else begin
               $display("A sample arrived after ch_on fell.");
               other_errors++;
            end
            next_cycle();
         end
      end

      $display("Errors: %0d wrong values, %0d other failures, %0d protocol failures",
               value_errors, other_errors, dut_i.protocol_chk_i.fail_count);
      if (value_errors + other_errors + int'(dut_i.protocol_chk_i.fail_count) == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// ==== files.f ====
snd_regs_pkg.sv
snd_timing_pkg.sv
noise_regs.sv
noise_tick_gen.sv
noise_env_length.sv
noise_lfsr_out.sv
noise_channel_top.sv
noise_channel_assertions.sv
noise_channel_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= noise_channel_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' files.f)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) files.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f files.f

run: $(BIN)
	./$(BIN) $(SIM_ARGS) | tee $(LOG)
	grep -qx "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
